// File: Bender.yml
package:
  name: sdram_port

sources:
  - files:
      - rtl/sdram_port_pkg.sv
      - rtl/line_read_cache.sv
      - rtl/stream_write_buffer.sv
      - rtl/burst_sequencer.sv
      - rtl/sdram_port_top.sv
  - target: test
    files:
      - tests/sdram_ctrl_model.sv
      - tests/tb_sdram_port.sv

// File: compile.f
rtl/sdram_port_pkg.sv
rtl/line_read_cache.sv
rtl/stream_write_buffer.sv
rtl/burst_sequencer.sv
rtl/sdram_port_top.sv
tests/sdram_ctrl_model.sv
tests/tb_sdram_port.sv

// File: rtl/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  logic                                    fill_req,
  input  sdram_port_pkg::line_tag_t               fill_tag,
  input  logic                                    one_req,
  input  sdram_port_pkg::word_addr_t              one_addr,
  input  sdram_port_pkg::word_t                   one_data,
  input  logic                                    block_req,
  input  sdram_port_pkg::block_tag_t              block_tag,
  input  sdram_port_pkg::word_t                   block_word,
  input  logic                                    mem_wr_ack,
  input  logic                                    mem_rd_ack,
  input  sdram_port_pkg::word_t                   mem_dout,
  output logic                                    fill_we,
  output logic [sdram_port_pkg::LINE_IDX_W-1:0]   fill_idx,
  output sdram_port_pkg::word_t                   fill_data,
  output logic                                    fill_done,
  output logic                                    one_done,
  output logic                                    block_done,
  output logic [sdram_port_pkg::STREAM_IDX_W-1:0] block_idx,
  output sdram_port_pkg::word_addr_t              mem_addr,
  output sdram_port_pkg::burst_len_t              mem_burst,
  output sdram_port_pkg::word_t                   mem_din,
  output logic                                    mem_wr_req,
  output logic                                    mem_rd_req,
  output logic                                    busy
);
  import sdram_port_pkg::*;

  seq_state_t state_q;
  seq_state_t pick_state;
  word_addr_t pick_addr;
  burst_len_t pick_burst;
  burst_len_t beat_q;
  logic       beat_ack;
  logic       last_beat;

  // fixed priority: line fill, single write, block flush
  always_comb begin
    pick_state = SEQ_IDLE;
    pick_addr  = '0;
    pick_burst = '0;
    if (fill_req) begin
      pick_state = SEQ_READ_LINE;
      pick_addr  = {fill_tag, {LINE_IDX_W{1'b0}}};
      pick_burst = BURST_W'(LINE_WORDS);
    end else if (one_req) begin
      pick_state = SEQ_WRITE_ONE;
      pick_addr  = one_addr;
      pick_burst = BURST_W'(1);
    end else if (block_req) begin
      pick_state = SEQ_WRITE_BLOCK;
      pick_addr  = {block_tag, {STREAM_IDX_W{1'b0}}};
      pick_burst = BURST_W'(STREAM_WORDS);
    end
  end

  assign beat_ack  = (state_q == SEQ_READ_LINE) ? mem_rd_ack : mem_wr_ack;
  assign last_beat = beat_ack && (beat_q == mem_burst - 1'b1);

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state_q    <= SEQ_IDLE;
      beat_q     <= '0;
      mem_rd_req <= 1'b0;
      mem_wr_req <= 1'b0;
      fill_done  <= 1'b0;
      one_done   <= 1'b0;
      block_done <= 1'b0;
    end else begin
      fill_done  <= 1'b0;
      one_done   <= 1'b0;
      block_done <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          beat_q     <= '0;
          state_q    <= pick_state;
          mem_rd_req <= (pick_state == SEQ_READ_LINE);
          mem_wr_req <= (pick_state == SEQ_WRITE_ONE) || (pick_state == SEQ_WRITE_BLOCK);
        end
        SEQ_READ_LINE, SEQ_WRITE_ONE, SEQ_WRITE_BLOCK: begin
          if (beat_ack) begin
            beat_q <= beat_q + 1'b1;
          end
          if (last_beat) begin
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            state_q    <= SEQ_DONE;
            fill_done  <= (state_q == SEQ_READ_LINE);  // pulses land in SEQ_DONE
            one_done   <= (state_q == SEQ_WRITE_ONE);
            block_done <= (state_q == SEQ_WRITE_BLOCK);
          end
        end
        SEQ_DONE: begin
          state_q <= SEQ_IDLE;
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // address and length held for the whole burst
  always_ff @(posedge clk) begin
    if (state_q == SEQ_IDLE) begin
      mem_addr  <= pick_addr;
      mem_burst <= pick_burst;
    end
  end

  assign fill_we   = (state_q == SEQ_READ_LINE) && mem_rd_ack;
  assign fill_idx  = beat_q[LINE_IDX_W-1:0];
  assign fill_data = mem_dout;
  assign block_idx = beat_q[STREAM_IDX_W-1:0];
  assign mem_din   = (state_q == SEQ_WRITE_BLOCK) ? block_word : one_data;
  assign busy      = (state_q != SEQ_IDLE);

endmodule

`default_nettype wire

// File: rtl/line_read_cache.sv
`timescale 1ns/1ps
`default_nettype none

module line_read_cache (
  input  logic                                  clk,
  input  logic                                  sys_rst_n,
  input  sdram_port_pkg::word_addr_t            address,
  input  logic                                  read_req,
  input  logic                                  write_req,
  input  logic                                  write_en,
  input  logic                                  fill_we,
  input  logic [sdram_port_pkg::LINE_IDX_W-1:0] fill_idx,
  input  sdram_port_pkg::word_t                 fill_data,
  input  logic                                  fill_done,
  output logic                                  fill_req,
  output sdram_port_pkg::line_tag_t             fill_tag,
  output sdram_port_pkg::word_t                 data_out,
  output logic                                  read_ack
);
  import sdram_port_pkg::*;

  logic                  read_req_q;
  logic                  read_rise;
  logic                  line_valid;
  line_tag_t             line_tag;
  line_tag_t             addr_tag;
  logic [LINE_IDX_W-1:0] addr_idx;
  logic                  tag_hit;
  word_t                 line_q [LINE_WORDS];

  assign addr_tag  = address[ADDR_W-1:LINE_IDX_W];
  assign addr_idx  = address[LINE_IDX_W-1:0];
  assign read_rise = read_req & ~read_req_q;
  assign tag_hit   = line_valid && (line_tag == addr_tag);

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_req_q <= 1'b0;
    end else begin
      read_req_q <= read_req;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_ack   <= 1'b0;
      data_out   <= '0;
      fill_req   <= 1'b0;
      line_valid <= 1'b0;
    end else begin
      if (fill_done) begin
        fill_req   <= 1'b0;
        line_valid <= 1'b1;
      end
      if (read_rise) begin
        if (tag_hit) begin
          read_ack <= 1'b1;
          data_out <= line_q[addr_idx];
        end else begin
          line_valid <= 1'b0;  // refetch whole line
          fill_req   <= 1'b1;
        end
      end else if (read_req) begin
        if (fill_done) begin
          read_ack <= 1'b1;
          data_out <= line_q[addr_idx];
        end
      end else begin
        read_ack <= 1'b0;
        data_out <= '0;
        if (write_req || write_en) begin
          line_valid <= 1'b0;  // line may be stale now
        end
      end
    end
  end

  // line words and tags
  always_ff @(posedge clk) begin
    if (fill_we) begin
      line_q[fill_idx] <= fill_data;
    end
    if (read_rise && !tag_hit) begin
      fill_tag <= addr_tag;
    end
    if (fill_done) begin
      line_tag <= fill_tag;
    end
  end

endmodule

`default_nettype wire

// File: rtl/sdram_port_pkg.sv
`default_nettype none

package sdram_port_pkg;

  localparam int ADDR_W       = 20;
  localparam int DATA_W       = 16;

  // read line geometry
  localparam int LINE_WORDS   = 4;
  localparam int LINE_IDX_W   = 2;

  // streaming block geometry
  localparam int STREAM_WORDS = 16;
  localparam int STREAM_IDX_W = 4;

  localparam int BURST_W      = 5;  // holds burst lengths up to 16

  typedef logic [ADDR_W-1:0]              word_addr_t;
  typedef logic [DATA_W-1:0]              word_t;
  typedef logic [ADDR_W-LINE_IDX_W-1:0]   line_tag_t;
  typedef logic [ADDR_W-STREAM_IDX_W-1:0] block_tag_t;
  typedef logic [BURST_W-1:0]             burst_len_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_READ_LINE,
    SEQ_WRITE_ONE,
    SEQ_WRITE_BLOCK,
    SEQ_DONE
  } seq_state_t;

endpackage

`default_nettype wire

// File: rtl/sdram_port_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port_top (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_port_pkg::word_addr_t address,
  input  sdram_port_pkg::word_t      data_in,
  input  logic                       read_req,
  input  logic                       write_req,
  input  logic                       write_latch_address,
  input  logic                       write_en,
  output sdram_port_pkg::word_t      data_out,
  output logic                       read_ack,
  output logic                       write_ack,
  output logic                       busy,
  input  logic                       mem_wr_ack,
  input  logic                       mem_rd_ack,
  input  sdram_port_pkg::word_t      mem_dout,
  output sdram_port_pkg::word_addr_t mem_addr,
  output sdram_port_pkg::burst_len_t mem_burst,
  output sdram_port_pkg::word_t      mem_din,
  output logic                       mem_wr_req,
  output logic                       mem_rd_req
);
  import sdram_port_pkg::*;

  // read side
  logic                    fill_req;
  line_tag_t               fill_tag;
  logic                    fill_we;
  logic [LINE_IDX_W-1:0]   fill_idx;
  word_t                   fill_data;
  logic                    fill_done;

  // write side
  logic                    one_req;
  word_addr_t              one_addr;
  word_t                   one_data;
  logic                    one_done;
  logic                    block_req;
  block_tag_t              block_tag;
  word_t                   block_word;
  logic                    block_done;
  logic [STREAM_IDX_W-1:0] block_idx;

  line_read_cache u_cache (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .address   (address),
    .read_req  (read_req),
    .write_req (write_req),
    .write_en  (write_en),
    .fill_we   (fill_we),
    .fill_idx  (fill_idx),
    .fill_data (fill_data),
    .fill_done (fill_done),
    .fill_req  (fill_req),
    .fill_tag  (fill_tag),
    .data_out  (data_out),
    .read_ack  (read_ack)
  );

  stream_write_buffer u_wbuf (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .address             (address),
    .data_in             (data_in),
    .write_req           (write_req),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .one_done            (one_done),
    .block_done          (block_done),
    .block_idx           (block_idx),
    .one_req             (one_req),
    .one_addr            (one_addr),
    .one_data            (one_data),
    .write_ack           (write_ack),
    .block_req           (block_req),
    .block_tag           (block_tag),
    .block_word          (block_word)
  );

  burst_sequencer u_seq (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .fill_req   (fill_req),
    .fill_tag   (fill_tag),
    .one_req    (one_req),
    .one_addr   (one_addr),
    .one_data   (one_data),
    .block_req  (block_req),
    .block_tag  (block_tag),
    .block_word (block_word),
    .mem_wr_ack (mem_wr_ack),
    .mem_rd_ack (mem_rd_ack),
    .mem_dout   (mem_dout),
    .fill_we    (fill_we),
    .fill_idx   (fill_idx),
    .fill_data  (fill_data),
    .fill_done  (fill_done),
    .one_done   (one_done),
    .block_done (block_done),
    .block_idx  (block_idx),
    .mem_addr   (mem_addr),
    .mem_burst  (mem_burst),
    .mem_din    (mem_din),
    .mem_wr_req (mem_wr_req),
    .mem_rd_req (mem_rd_req),
    .busy       (busy)
  );

endmodule

`default_nettype wire

// File: rtl/stream_write_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_write_buffer (
  input  logic                                    clk,
  input  logic                                    sys_rst_n,
  input  sdram_port_pkg::word_addr_t              address,
  input  sdram_port_pkg::word_t                   data_in,
  input  logic                                    write_req,
  input  logic                                    write_latch_address,
  input  logic                                    write_en,
  input  logic                                    one_done,
  input  logic                                    block_done,
  input  logic [sdram_port_pkg::STREAM_IDX_W-1:0] block_idx,
  output logic                                    one_req,
  output sdram_port_pkg::word_addr_t              one_addr,
  output sdram_port_pkg::word_t                   one_data,
  output logic                                    write_ack,
  output logic                                    block_req,
  output sdram_port_pkg::block_tag_t              block_tag,
  output sdram_port_pkg::word_t                   block_word
);
  import sdram_port_pkg::*;

  logic                    write_req_q;
  logic                    write_rise;
  word_addr_t              stream_addr_q;
  word_addr_t              stream_addr;
  logic [STREAM_IDX_W-1:0] stream_slot;
  logic                    slot_last;
  word_t                   front_q [STREAM_WORDS];
  word_t                   back_q  [STREAM_WORDS];

  assign write_rise  = write_req & ~write_req_q;
  assign stream_addr = write_latch_address ? address : stream_addr_q;
  assign stream_slot = stream_addr[STREAM_IDX_W-1:0];
  assign slot_last   = write_en && (stream_slot == STREAM_IDX_W'(STREAM_WORDS - 1));
  assign block_word  = back_q[block_idx];

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      write_req_q <= 1'b0;
      one_req     <= 1'b0;
      write_ack   <= 1'b0;
    end else begin
      write_req_q <= write_req;
      write_ack   <= one_done;  // one cycle after the burst ends
      if (write_rise) begin
        one_req <= 1'b1;
      end else if (one_done) begin
        one_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_rise) begin
      one_addr <= address;
      one_data <= data_in;
    end
  end

  // running stream address
  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stream_addr_q <= '0;
    end else if (write_en) begin
      stream_addr_q <= stream_addr + 1'b1;
    end else begin
      stream_addr_q <= stream_addr;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      block_req <= 1'b0;
    end else begin
      if (block_done) begin
        block_req <= 1'b0;
      end
      if (slot_last) begin
        block_req <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_en) begin
      front_q[stream_slot] <= data_in;
    end
    if (slot_last) begin
      // hand the finished block over, last word comes straight from data_in
      back_q                 <= front_q;
      back_q[STREAM_WORDS-1] <= data_in;
      block_tag              <= stream_addr[ADDR_W-1:STREAM_IDX_W];
    end
  end

endmodule

`default_nettype wire

// File: tests/sdram_ctrl_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_model (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_port_pkg::word_addr_t mem_addr,
  input  sdram_port_pkg::burst_len_t mem_burst,
  input  sdram_port_pkg::word_t      mem_din,
  input  logic                       mem_wr_req,
  input  logic                       mem_rd_req,
  output logic                       mem_wr_ack,
  output logic                       mem_rd_ack,
  output sdram_port_pkg::word_t      mem_dout
);
  import sdram_port_pkg::*;

  typedef enum logic [1:0] {
    CTL_IDLE,
    CTL_WAIT,
    CTL_BEAT,
    CTL_RELEASE
  } ctl_state_t;

  ctl_state_t state_q;
  logic       is_read_q;
  logic [2:0] wait_q;
  logic [2:0] delay_q;
  burst_len_t beat_q;
  word_t      mem_q [word_addr_t];

  function automatic word_t read_word(input word_addr_t a);
    if (mem_q.exists(a)) begin
      return mem_q[a];
    end
    return word_t'(a ^ (a >> 4));  // untouched locations
  endfunction

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state_q    <= CTL_IDLE;
      is_read_q  <= 1'b0;
      wait_q     <= '0;
      delay_q    <= '0;
      beat_q     <= '0;
      mem_rd_ack <= 1'b0;
      mem_wr_ack <= 1'b0;
      mem_dout   <= '0;
    end else begin
      case (state_q)
        CTL_IDLE: begin
          if (mem_rd_req || mem_wr_req) begin
            is_read_q <= mem_rd_req;
            wait_q    <= delay_q;
            delay_q   <= (delay_q == 3'd4) ? 3'd0 : delay_q + 3'd1;  // ack delay 0..4
            state_q   <= CTL_WAIT;
          end
        end
        CTL_WAIT: begin
          if (wait_q == 3'd0) begin
            beat_q     <= '0;
            mem_rd_ack <= is_read_q;
            mem_wr_ack <= !is_read_q;
            mem_dout   <= is_read_q ? read_word(mem_addr) : '0;
            state_q    <= CTL_BEAT;
          end else begin
            wait_q <= wait_q - 3'd1;
          end
        end
        CTL_BEAT: begin
          if (!is_read_q) begin
            mem_q[mem_addr + word_addr_t'(beat_q)] = mem_din;
          end
          if (beat_q == mem_burst - 1'b1) begin
            mem_rd_ack <= 1'b0;
            mem_wr_ack <= 1'b0;
            mem_dout   <= '0;
            state_q    <= CTL_RELEASE;
          end else begin
            beat_q <= beat_q + 1'b1;
            if (is_read_q) begin
              mem_dout <= read_word(mem_addr + word_addr_t'(beat_q) + 1'b1);
            end
          end
        end
        default: begin
          if (!mem_rd_req && !mem_wr_req) begin
            state_q <= CTL_IDLE;  // wait for request release
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_sdram_port.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_port;
  import sdram_port_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int MAX_OPS        = 64;
  localparam int OP_CYCLES      = 60;
  localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES + RESET_CYCLES;

  logic       clk;
  logic       sys_rst_n;
  word_addr_t address;
  word_t      data_in;
  logic       read_req;
  logic       write_req;
  logic       write_latch_address;
  logic       write_en;
  word_t      data_out;
  logic       read_ack;
  logic       write_ack;
  logic       busy;
  logic       mem_wr_ack;
  logic       mem_rd_ack;
  word_t      mem_dout;
  word_addr_t mem_addr;
  burst_len_t mem_burst;
  word_t      mem_din;
  logic       mem_wr_req;
  logic       mem_rd_req;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [15:0] lfsr_q;
  word_t       ref_mem [word_addr_t];

  sdram_port_top dut0 (.*);

  sdram_ctrl_model ctrl0 (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  assert property (@(posedge clk) disable iff (!sys_rst_n) !(mem_rd_req && mem_wr_req))
    else begin
      errors++;
      $display("Error at %0t: mem_rd_req and mem_wr_req high together", $time);
    end

  assert property (@(posedge clk) disable iff (!sys_rst_n) (mem_rd_req || mem_wr_req) |-> busy)
    else begin
      errors++;
      $display("Error at %0t: controller request while busy is low", $time);
    end

  assert property (@(posedge clk) disable iff (!sys_rst_n) !read_ack |-> (data_out == '0))
    else begin
      errors++;
      $display("Error at %0t: data_out %h while read_ack is low", $time, data_out);
    end

  // line fill is an aligned burst of four
  assert property (@(posedge clk) disable iff (!sys_rst_n)
      mem_rd_req |-> (mem_burst == LINE_WORDS && mem_addr[LINE_IDX_W-1:0] == '0))
    else begin
      errors++;
      $display("Error at %0t: read burst %0d at %h", $time, mem_burst, mem_addr);
    end

  assert property (@(posedge clk) disable iff (!sys_rst_n)
      mem_wr_req |-> (mem_burst == 1 ||
                      (mem_burst == STREAM_WORDS && mem_addr[STREAM_IDX_W-1:0] == '0)))
    else begin
      errors++;
      $display("Error at %0t: write burst %0d at %h", $time, mem_burst, mem_addr);
    end

  // fibonacci taps 16,14,13,11
  function automatic logic [ADDR_W-1:0] take_bits(input int n);
    logic              fb;
    logic [ADDR_W-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[ADDR_W-2:0], fb};
    end
    return v;
  endfunction

  function automatic word_t expect_word(input word_addr_t a);
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    return word_t'(a ^ (a >> 4));  // controller power-up contents
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // expect_fill 0 means hit, 1 new fill, -1 either
  task automatic read_and_check(input word_addr_t a, input int expect_fill);
    int   waited;
    logic saw_fill;
    waited   = 0;
    saw_fill = 1'b0;
    @(negedge clk);
    address  = a;
    read_req = 1'b1;
    do begin
      @(negedge clk);
      waited++;
      saw_fill = saw_fill | mem_rd_req;
    end while (!read_ack);
    if (expect_fill == 0) begin
      check_value("hit latency", waited, 1);
      check_value("mem_rd_req during hit", saw_fill, 0);
    end else if (expect_fill == 1) begin
      check_value("line refill", saw_fill, 1);
    end
    check_value($sformatf("data_out at %h", a), data_out, expect_word(a));
    read_req = 1'b0;
    @(negedge clk);
    check_value("read_ack after release", read_ack, 0);
  endtask

  task automatic write_single(input word_addr_t a, input word_t d);
    @(negedge clk);
    address   = a;
    data_in   = d;
    write_req = 1'b1;
    ref_mem[a] = d;
    @(negedge clk);
    write_req = 1'b0;
    while (!write_ack) @(negedge clk);
    @(negedge clk);
    check_value("write_ack pulse width", write_ack, 0);
  endtask

  task automatic stream_block(input word_addr_t base);
    logic [ADDR_W-1:0] r;
    for (int k = 0; k < STREAM_WORDS; k++) begin
      r = take_bits(DATA_W);
      @(negedge clk);
      address             = base;
      write_latch_address = (k == 0);
      write_en            = 1'b1;
      data_in             = r[DATA_W-1:0];
      ref_mem[word_addr_t'(base + k)] = r[DATA_W-1:0];
    end
    @(negedge clk);
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    while (!busy) @(negedge clk);  // flush starts
    while (busy) @(negedge clk);
  endtask

  initial begin
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] d;
    lfsr_q              = 16'd73;
    sys_rst_n           = 1'b0;
    address             = '0;
    data_in             = '0;
    read_req            = 1'b0;
    write_req           = 1'b0;
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    sys_rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_value("idle outputs", {read_ack, write_ack, busy, mem_rd_req, mem_wr_req}, 0);
    end

    for (int i = 0; i < 4; i++) begin
      a = take_bits(ADDR_W);
      d = take_bits(DATA_W);
      write_single(a, d[DATA_W-1:0]);
      read_and_check(a, 1);
      read_and_check(a ^ 20'h1, 0);  // same line
    end

    a = take_bits(ADDR_W);
    a[STREAM_IDX_W-1:0] = '0;
    stream_block(a);
    for (int k = 0; k < STREAM_WORDS; k++) begin
      read_and_check(word_addr_t'(a + k), (k % LINE_WORDS == 0) ? 1 : 0);
    end

    // write into the cached line and read it again
    a = take_bits(ADDR_W);
    read_and_check(a, -1);
    read_and_check(a, 0);
    d = take_bits(DATA_W);
    write_single(a ^ 20'h2, d[DATA_W-1:0]);
    read_and_check(a, 1);
    read_and_check(a ^ 20'h2, 0);

    repeat (4) @(negedge clk);
    $display("tb_sdram_port: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
